// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = tb_cam_edge
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_TEXT = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== sources.f ====
+incdir+verilog
verilog/video_pkg.sv
verilog/line_delay.sv
verilog/cmos_capture.sv
verilog/frame_buffer.sv
verilog/tft_timing.sv
verilog/sobel_edge.sv
verilog/cam_edge_top.sv
testbench/tb_cam_edge.sv

// ==== testbench/tb_cam_edge.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module tb_cam_edge
	import video_pkg::*;
();

	localparam int WAIT_LIMIT = 4000; // clocks, far above one display frame

	logic       clk = 1'b0;
	logic       rst;
	logic       cmos_vsync;
	logic       cmos_href;
	logic [7:0] cmos_data;
	logic       tft_de;
	logic       tft_hs;
	logic       tft_vs;
	pixel_t     tft_rgb;

	pixel_t cam_img [`FRAME_PIXELS]; // frame handed to the camera
	pixel_t exp_img [`FRAME_PIXELS]; // model result
	pixel_t got_img [`FRAME_PIXELS]; // display capture
	int     got_cnt; // de samples seen
	int     de_runs;
	int     bad_runs; // runs not H_ACTIVE long
	int     hs_pulses;
	int     bad_hs; // pulses not H_SYNC long
	int     n_checks = 0;
	int     n_errors = 0;
	int     seed = 62313;
	logic   sending; // junk frames in flight

	cam_edge_top u_dut (.clk(clk), .rst(rst), .cmos_vsync(cmos_vsync), .cmos_href(cmos_href),
		.cmos_data(cmos_data), .tft_de(tft_de), .tft_hs(tft_hs), .tft_vs(tft_vs),
		.tft_rgb(tft_rgb));

	always #20 clk = ~clk; // 40 ns period

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string why);
		n_errors++;
		$display("timeout: %s", why);
	endtask

	function automatic pixel_t green_pixel(input int g);
		return pixel_t'(((g & 63) << 5) | 32'hA812); // fixed red and blue around it
	endfunction

	// zero outside the active area, like the blanking fill
	function automatic int green_at(input int r, input int c);
		if (r < 0 || r >= `V_ACTIVE || c < 0 || c >= `H_ACTIVE)
			return 0;
		return int'(cam_img[r * `H_ACTIVE + c][10:5]);
	endfunction

	function automatic void model_frame();
		int gx;
		int gy;
		for (int r = 0; r < `V_ACTIVE; r++) begin
			for (int c = 0; c < `H_ACTIVE; c++) begin
				gx = green_at(r - 1, c + 1) + 2 * green_at(r, c + 1) + green_at(r + 1, c + 1)
					- green_at(r - 1, c - 1) - 2 * green_at(r, c - 1) - green_at(r + 1, c - 1);
				gy = green_at(r - 1, c - 1) + 2 * green_at(r - 1, c) + green_at(r - 1, c + 1)
					- green_at(r + 1, c - 1) - 2 * green_at(r + 1, c) - green_at(r + 1, c + 1);
				if (gx < 0)
					gx = -gx;
				if (gy < 0)
					gy = -gy;
				exp_img[r * `H_ACTIVE + c] = (gx + gy > `EDGE_THRESHOLD) ? 16'hFFFF : 16'h0000;
			end
		end
	endfunction

	task automatic send_frame();
		repeat (5) @(posedge clk); // vsync high, blanking
		cmos_vsync <= 1'b0; // falling edge opens the frame
		for (int r = 0; r < `V_ACTIVE; r++) begin
			repeat (3) @(posedge clk); // href gap
			for (int c = 0; c < `H_ACTIVE; c++) begin
				@(posedge clk);
				cmos_href <= 1'b1;
				cmos_data <= cam_img[r * `H_ACTIVE + c][15:8]; // high byte first
				@(posedge clk);
				cmos_data <= cam_img[r * `H_ACTIVE + c][7:0];
			end
			@(posedge clk);
			cmos_href <= 1'b0;
		end
		repeat (3) @(posedge clk); // last write and frame_done land here
		cmos_vsync <= 1'b1;
	endtask

	// returns on the clock where tft_vs has just changed to level
	task automatic wait_vs(input logic level, input string why);
		int   n;
		logic prev;
		logic cur;
		n = 0;
		@(posedge clk);
		cur = tft_vs;
		prev = cur;
		while (!(prev !== level && cur === level) && n < WAIT_LIMIT) begin
			prev = cur;
			@(posedge clk);
			cur = tft_vs;
			n++;
		end
		if (!(prev !== level && cur === level))
			report_timeout(why);
	endtask

	// one display frame, vs rise to next vs fall
	task automatic collect_frame();
		int   n;
		int   run_len;
		int   hs_len;
		logic de_prev;
		logic hs_prev;
		wait_vs(1'b1, "tft_vs did not return high");
		n = 0;
		run_len = 0;
		hs_len = 0;
		de_prev = 1'b0;
		hs_prev = 1'b1;
		got_cnt = 0;
		de_runs = 0;
		bad_runs = 0;
		hs_pulses = 0;
		bad_hs = 0;
		@(posedge clk);
		while (tft_vs === 1'b1 && n < WAIT_LIMIT) begin
			if (tft_de === 1'b1) begin
				if (got_cnt < `FRAME_PIXELS)
					got_img[got_cnt] = tft_rgb;
				got_cnt++;
				run_len++;
			end else if (de_prev === 1'b1) begin
				de_runs++; // run just ended
				if (run_len != `H_ACTIVE)
					bad_runs++;
				run_len = 0;
			end
			if (tft_hs === 1'b0) begin
				hs_len++;
			end else if (hs_prev === 1'b0) begin
				hs_pulses++;
				if (hs_len != `H_SYNC)
					bad_hs++;
				hs_len = 0;
			end
			de_prev = tft_de;
			hs_prev = tft_hs;
			@(posedge clk);
			n++;
		end
		if (tft_vs === 1'b1)
			report_timeout("tft_vs never went low to close the display frame");
	endtask

	// skips the frame already on screen, judges the next whole one
	task automatic check_display(input string name);
		wait_vs(1'b0, "no vs pulse on the display after the camera frame");
		collect_frame();
		check_value({name, ": pixel count"}, got_cnt, `FRAME_PIXELS);
		for (int i = 0; i < `FRAME_PIXELS; i++)
			check_value($sformatf("%s: pixel %0d", name, i), 32'(got_img[i]),
				32'(exp_img[i]));
	endtask

	task automatic test_reset_skip();
		sending = 1'b1;
		fork
			begin
				for (int i = 0; i < `FRAME_PIXELS; i++)
					cam_img[i] = pixel_t'(i * 40503);
				send_frame();
				for (int i = 0; i < `FRAME_PIXELS; i++)
					cam_img[i] = pixel_t'(~(i * 777));
				send_frame();
				sending = 1'b0;
			end
			begin
				while (sending) begin
					@(posedge clk);
					check_value("tft_de while frames are skipped", 32'(tft_de), 0);
					check_value("tft_vs while frames are skipped", 32'(tft_vs), 1);
					check_value("tft_hs while frames are skipped", 32'(tft_hs), 1);
					check_value("tft_rgb while frames are skipped", 32'(tft_rgb), 0);
				end
			end
		join
	endtask

	task automatic test_flat_after_skip();
		for (int i = 0; i < `FRAME_PIXELS; i++)
			cam_img[i] = green_pixel(20);
		send_frame();
		model_frame(); // white border only
		check_display("flat frame");
	endtask

	task automatic test_byte_order();
		for (int i = 0; i < `FRAME_PIXELS; i++)
			cam_img[i] = (i % `H_ACTIVE >= 8) ? 16'h07E0 : 16'h0000; // swapped reads as all zero
		send_frame();
		model_frame();
		check_display("byte order step");
	endtask

	task automatic test_threshold();
		int g;
		for (int r = 0; r < `V_ACTIVE; r++) begin
			for (int c = 0; c < `H_ACTIVE; c++) begin
				g = 20;
				if (r >= 3 && c >= 3 && c < 8)
					g++; // block corners give magnitude 6
				if (c >= 10)
					g += c - 10; // slope 1 gives 8 inside
				cam_img[r * `H_ACTIVE + c] = green_pixel(g);
			end
		end
		send_frame();
		model_frame();
		check_display("threshold ramp");
	endtask

	task automatic test_scan_structure();
		wait_vs(1'b0, "no vs pulse before the scan check");
		collect_frame();
		check_value("de runs per frame", de_runs, `V_ACTIVE);
		check_value("de runs of wrong length", bad_runs, 0);
		check_value("hs pulses, one per line", hs_pulses, `V_TOTAL - `V_SYNC);
		check_value("hs pulses of wrong width", bad_hs, 0);
	endtask

	task automatic test_random_update();
		for (int i = 0; i < `FRAME_PIXELS; i++)
			cam_img[i] = pixel_t'($random(seed));
		send_frame();
		model_frame();
		check_display("random frame");
	endtask

	initial begin
		rst <= 1'b1;
		cmos_vsync <= 1'b1; // camera starts in blanking
		cmos_href <= 1'b0;
		cmos_data <= 8'h00;
		sending = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		test_reset_skip();
		test_flat_after_skip();
		test_byte_order();
		test_threshold();
		test_scan_structure();
		test_random_update();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== verilog/cam_edge_top.sv ====
`timescale 1ns/1ps

module cam_edge_top
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cmos_vsync,
	input  logic       cmos_href,
	input  logic [7:0] cmos_data,
	output logic       tft_de,
	output logic       tft_hs,
	output logic       tft_vs,
	output pixel_t     tft_rgb
);

	logic   wr_en; // capture write strobe
	addr_t  wr_addr;
	pixel_t wr_data;
	logic   frame_done; // last pixel of a kept frame written
	logic   frame_ready; // gates display start
	logic   rd_en; // display fetch
	addr_t  rd_addr;
	pixel_t rd_data; // one clock after rd_en
	sync_t  scan_sync;

	cmos_capture u_capture (.clk(clk), .rst(rst), .cmos_vsync(cmos_vsync),
		.cmos_href(cmos_href), .cmos_data(cmos_data), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data), .frame_done(frame_done));

	frame_buffer u_fbuf (.clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data), .frame_done(frame_done), .rd_en(rd_en), .rd_addr(rd_addr),
		.rd_data(rd_data), .frame_ready(frame_ready));

	tft_timing u_timing (.clk(clk), .rst(rst), .frame_ready(frame_ready),
		.scan_sync(scan_sync), .rd_en(rd_en), .rd_addr(rd_addr));

	sobel_edge u_sobel (.clk(clk), .rst(rst), .scan_sync(scan_sync), .rd_data(rd_data),
		.tft_de(tft_de), .tft_hs(tft_hs), .tft_vs(tft_vs), .tft_rgb(tft_rgb));

endmodule

// ==== verilog/cmos_capture.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module cmos_capture
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cmos_vsync,
	input  logic       cmos_href,
	input  logic [7:0] cmos_data,
	output logic       wr_en,
	output addr_t      wr_addr,
	output pixel_t     wr_data,
	output logic       frame_done
);

	localparam int SKIP_W = $clog2(`CMOS_FRAME_WAITCNT + 1);

	logic                vsync_d; // vsync one clock late
	logic                frame_start; // vsync falling edge
	logic                byte_vld; // camera byte on this clock
	logic [SKIP_W-1:0]   skip_cnt; // frames seen so far, saturating
	logic                keep; // current frame goes to memory
	logic                keep_now;
	logic                phase; // 1 = waiting for low byte
	logic                phase_now;
	logic [7:0]          hi_byte; // first byte of the pair
	logic [`ADDR_W:0]    pix_cnt; // one spare bit to see overflow
	logic [`ADDR_W:0]    cnt_now;
	logic                in_range;

	assign frame_start = vsync_d & ~cmos_vsync;
	assign byte_vld    = cmos_href & ~cmos_vsync;

	// frame start takes effect on the same clock, so a byte here is not lost
	assign keep_now  = frame_start ? (skip_cnt == SKIP_W'(`CMOS_FRAME_WAITCNT)) : keep;
	assign phase_now = frame_start ? 1'b0 : phase;
	assign cnt_now   = frame_start ? '0 : pix_cnt;
	assign in_range  = (cnt_now < (`ADDR_W+1)'(`FRAME_PIXELS)); // drop excess pixels

	always_ff @(posedge clk) begin
		if (rst) begin
			vsync_d    <= 1'b0;
			skip_cnt   <= '0;
			keep       <= 1'b0;
			phase      <= 1'b0;
			pix_cnt    <= '0;
			wr_en      <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			vsync_d    <= cmos_vsync;
			keep       <= keep_now;
			phase      <= phase_now;
			pix_cnt    <= cnt_now;
			wr_en      <= 1'b0;
			frame_done <= wr_en && (wr_addr == addr_t'(`FRAME_PIXELS - 1)); // after last write
			if (frame_start && skip_cnt != SKIP_W'(`CMOS_FRAME_WAITCNT))
				skip_cnt <= skip_cnt + 1'b1;
			if (byte_vld) begin
				phase <= ~phase_now; // toggle hi/lo
				if (phase_now) begin
					wr_en <= keep_now && in_range; // skipped frames never write
					if (in_range)
						pix_cnt <= cnt_now + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_vld && !phase_now)
			hi_byte <= cmos_data; // high byte arrives first
		if (byte_vld && phase_now) begin
			wr_data <= {hi_byte, cmos_data};
			wr_addr <= cnt_now[`ADDR_W-1:0];
		end
	end

	// write index, taken on the wide counter, stays inside the frame
	a_wr_in_frame: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> (pix_cnt == {1'b0, wr_addr} + 1'b1)
			&& (pix_cnt <= (`ADDR_W+1)'(`FRAME_PIXELS)));

endmodule

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module frame_buffer
	import video_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   wr_en,
	input  addr_t  wr_addr,
	input  pixel_t wr_data,
	input  logic   frame_done,
	input  logic   rd_en,
	input  addr_t  rd_addr,
	output pixel_t rd_data,
	output logic   frame_ready
);

	pixel_t mem [`FRAME_PIXELS]; // one full frame, single buffered

	// write port, camera side
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read port, display side; same-address collision gives old word
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr]; // 1 clock latency
	end

	// set by first complete kept frame
	always_ff @(posedge clk) begin
		if (rst)
			frame_ready <= 1'b0;
		else if (frame_done)
			frame_ready <= 1'b1; // sticky until reset
	end

	a_no_read_before_ready: assert property (@(posedge clk) disable iff (rst)
		rd_en |-> frame_ready);

endmodule

// ==== verilog/line_delay.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module line_delay #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t din,
	output payload_t dout
);

	localparam int DEPTH = `H_TOTAL; // exactly one display line
	localparam int PTR_W = $clog2(DEPTH);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] ptr; // write slot = oldest entry
	logic             wrapped; // ring filled once

	always_ff @(posedge clk) begin
		mem[ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr     <= '0;
			wrapped <= 1'b0;
		end else begin
			ptr <= (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
			if (ptr == PTR_W'(DEPTH - 1))
				wrapped <= 1'b1;
		end
	end

	assign dout = wrapped ? mem[ptr] : '0; // read before overwrite
endmodule

// ==== verilog/sobel_edge.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module sobel_edge
	import video_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  sync_t  scan_sync,
	input  pixel_t rd_data,
	output logic   tft_de,
	output logic   tft_hs,
	output logic   tft_vs,
	output pixel_t tft_rgb
);

	sync_t  sync_d1; // lines up with rd_data
	sync_t  sync_fold; // hs/vs flipped to active high
	sync_t  sync_line; // one line later, still flipped
	sync_t  sync_d2; // matches window center
	green_t g_row0; // bottom row, current line
	green_t g_row1; // middle row
	green_t g_row2; // top row
	green_t r0_d1, r0_d2;
	green_t r1_d1, r1_d2;
	green_t r2_d1, r2_d2;
	mag_t   gx_p, gx_n; // right / left column sums
	mag_t   gy_p, gy_n; // top / bottom row sums
	mag_t   mag;
	logic   edge_hit;

	assign g_row0 = sync_d1.de ? rd_data[10:5] : '0; // blanking reads as zero

	// zero fill of the ring then means idle syncs
	always_comb begin
		sync_fold.de = sync_d1.de;
		sync_fold.hs = ~sync_d1.hs;
		sync_fold.vs = ~sync_d1.vs;
	end

	line_delay #(.payload_t(green_t)) u_row1 (.clk(clk), .rst(rst), .din(g_row0), .dout(g_row1));
	line_delay #(.payload_t(green_t)) u_row2 (.clk(clk), .rst(rst), .din(g_row1), .dout(g_row2));
	line_delay #(.payload_t(sync_t)) u_sync (.clk(clk), .rst(rst), .din(sync_fold),
		.dout(sync_line));

	always_ff @(posedge clk) begin
		r0_d1 <= g_row0; // column shift, 3 taps per row
		r0_d2 <= r0_d1;
		r1_d1 <= g_row1;
		r1_d2 <= r1_d1;
		r2_d1 <= g_row2;
		r2_d2 <= r2_d1;
	end

	always_comb begin
		gx_p = mag_t'(g_row2) + (mag_t'(g_row1) << 1) + mag_t'(g_row0);
		gx_n = mag_t'(r2_d2) + (mag_t'(r1_d2) << 1) + mag_t'(r0_d2);
		gy_p = mag_t'(r2_d2) + (mag_t'(r2_d1) << 1) + mag_t'(g_row2);
		gy_n = mag_t'(r0_d2) + (mag_t'(r0_d1) << 1) + mag_t'(g_row0);
		mag  = ((gx_p > gx_n) ? gx_p - gx_n : gx_n - gx_p)
		     + ((gy_p > gy_n) ? gy_p - gy_n : gy_n - gy_p); // |gx| + |gy|
	end

	assign edge_hit = (mag > mag_t'(`EDGE_THRESHOLD));

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_d1 <= '{de: 1'b0, hs: 1'b1, vs: 1'b1};
			sync_d2 <= '0;
			tft_de  <= 1'b0;
			tft_hs  <= 1'b1;
			tft_vs  <= 1'b1;
			tft_rgb <= '0;
		end else begin
			sync_d1 <= scan_sync;
			sync_d2 <= sync_line;
			tft_de  <= sync_d2.de;
			tft_hs  <= ~sync_d2.hs; // back to active low
			tft_vs  <= ~sync_d2.vs;
			tft_rgb <= (sync_d2.de && edge_hit) ? '1 : '0; // white edge, black else
		end
	end

	a_de_outside_sync: assert property (@(posedge clk) disable iff (rst)
		tft_de |-> (tft_hs && tft_vs)); // no active pixel inside a sync pulse

endmodule

// ==== verilog/tft_timing.sv ====
`timescale 1ns/1ps
`include "video_params.svh"

module tft_timing
	import video_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  frame_ready,
	output sync_t scan_sync,
	output logic  rd_en,
	output addr_t rd_addr
);

	localparam int HW       = $clog2(`H_TOTAL);
	localparam int VW       = $clog2(`V_TOTAL);
	localparam int HS_START = `H_ACTIVE + `H_FRONT; // active, then porch, then sync
	localparam int VS_START = `V_ACTIVE + `V_FRONT;

	logic          running; // latched once a frame is stored
	logic [HW-1:0] h_cnt;
	logic [VW-1:0] v_cnt;
	logic          line_end;
	logic          frame_end;
	logic          de;

	assign line_end  = (h_cnt == HW'(`H_TOTAL - 1));
	assign frame_end = line_end && (v_cnt == VW'(`V_TOTAL - 1));
	assign de        = running && (h_cnt < HW'(`H_ACTIVE)) && (v_cnt < VW'(`V_ACTIVE));

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			h_cnt   <= '0;
			v_cnt   <= '0;
			rd_addr <= '0;
		end else begin
			if (frame_ready)
				running <= 1'b1; // first pixel on the next clock, never stops
			if (running) begin
				h_cnt <= line_end ? '0 : h_cnt + 1'b1;
				if (line_end)
					v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
				if (frame_end)
					rd_addr <= '0; // back to top-left
				else if (de)
					rd_addr <= rd_addr + 1'b1; // raster order
			end
		end
	end

	always_comb begin
		scan_sync.de = de;
		scan_sync.hs = ~(running && (h_cnt >= HW'(HS_START))
			&& (h_cnt < HW'(HS_START + `H_SYNC)));
		scan_sync.vs = ~(running && (v_cnt >= VW'(VS_START))
			&& (v_cnt < VW'(VS_START + `V_SYNC)));
	end

	assign rd_en = de; // fetch only visible pixels

	a_hs_width: assert property (@(posedge clk) disable iff (rst)
		$fell(scan_sync.hs) |-> !scan_sync.hs [*`H_SYNC] ##1 scan_sync.hs);

endmodule

// ==== verilog/video_params.svh ====
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

`define H_ACTIVE 16 // visible pixels per line
`define H_FRONT 2 // front porch, pixels
`define H_SYNC 3 // hs pulse width
`define H_BACK 3 // back porch
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE 8 // visible lines per frame
`define V_FRONT 1 // front porch, lines
`define V_SYNC 1 // vs pulse width in lines
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define FRAME_PIXELS (`H_ACTIVE * `V_ACTIVE)
`define ADDR_W $clog2(`FRAME_PIXELS) // frame buffer address bits

`define CMOS_FRAME_WAITCNT 2 // unstable frames dropped after reset
`define EDGE_THRESHOLD 6 // white above this magnitude

`endif

// ==== verilog/video_pkg.sv ====
`include "video_params.svh"

package video_pkg;

	typedef logic [15:0] pixel_t; // rgb565, r[15:11] g[10:5] b[4:0]
	typedef logic [5:0] green_t; // g field only
	typedef logic [`ADDR_W-1:0] addr_t; // frame buffer index

	typedef struct packed {
		logic de; // active video
		logic hs; // low during h sync
		logic vs; // low during v sync
	} sync_t;

	typedef logic [9:0] mag_t; // |gx| + |gy|, max 504

endpackage
